/* include/poker_macros.svh */
`ifndef POKER_MACROS_SVH
`define POKER_MACROS_SVH

// one card is suit over rank
`define CARD_W 6

// rank field, ace is 1 and king is 13
`define RANK_W 4

// suit field in the upper bits of a card
`define SUIT_W 2

// cards in one hand
`define NUM_CARDS 5

// width of the category code
`define TYPE_W 4

// rank values at both ends of the deck
`define RANK_ACE 1
`define RANK_KING 13

// cards that make up a straight
`define STRAIGHT_LEN 5

`endif

/* design/pokerPkg.sv */
`include "poker_macros.svh"

package pokerPkg;

	// raw rank, compared as a plain number
	typedef logic [`RANK_W-1:0] rankT;

	// raw suit, only equality matters
	typedef logic [`SUIT_W-1:0] suitT;

	// suit sits above rank, same layout as the card pins
	typedef struct packed {
		suitT suit;
		rankT rank;
	} cardT;

	// card 0 in the low bits
	typedef cardT [`NUM_CARDS-1:0] handT;

	// codes in rising order of strength
	typedef enum logic [`TYPE_W-1:0] {
		highCard      = 4'd0,
		onePair       = 4'd1,
		twoPairs      = 4'd2,
		threeOfAKind  = 4'd3,
		straight      = 4'd4,
		flush         = 4'd5,
		fullHouse     = 4'd6,
		fourOfAKind   = 4'd7,
		straightFlush = 4'd8
	} handCategoryE;

endpackage

/* design/patternIf.sv */
`timescale 1ns/1ps

// rank patterns from the multiplicity stage
interface patternIf;

	// at most one of these is high
	logic fourOfAKind;
	logic fullHouse;
	logic threeOfAKind;
	logic twoPairs;
	logic onePair;

	// multiplicity stage side
	modport producer(output fourOfAKind, fullHouse, threeOfAKind, twoPairs, onePair);

	// ranker side
	modport consumer(input fourOfAKind, fullHouse, threeOfAKind, twoPairs, onePair);

endinterface

/* design/rankMultiplicity.sv */
`timescale 1ns/1ps
`include "poker_macros.svh"

module rankMultiplicity import pokerPkg::*; (
	input handT hand,
	patternIf.producer patterns
);

	// pairwise rank equality, only upper triangle is used
	logic sameRank [`NUM_CARDS][`NUM_CARDS];

	always_comb begin
		for (int i = 0; i < `NUM_CARDS; i++) begin
			for (int j = 0; j < `NUM_CARDS; j++) begin
				sameRank[i][j] = (hand[i].rank == hand[j].rank);
			end
		end
	end

	always_comb begin
		logic trioHit;
		logic anyPair;
		logic anyTrio;
		logic anyQuad;
		logic fullRaw;
		logic twoRaw;
		logic fourFlag;
		logic fullFlag;
		logic threeFlag;
		logic twoFlag;
		logic oneFlag;

		trioHit = 1'b0;
		anyPair = 1'b0;
		anyTrio = 1'b0;
		anyQuad = 1'b0;
		fullRaw = 1'b0;
		twoRaw  = 1'b0;

		// every trio a<b<c, then extend to quads or look for a pair in the rest
		for (int a = 0; a < `NUM_CARDS; a++) begin
			for (int b = a + 1; b < `NUM_CARDS; b++) begin
				for (int c = b + 1; c < `NUM_CARDS; c++) begin
					trioHit = sameRank[a][b] & sameRank[a][c];
					anyTrio |= trioHit;
					// fourth card above c closes a quad
					for (int d = c + 1; d < `NUM_CARDS; d++) begin
						anyQuad |= trioHit & sameRank[a][d];
					end
					// the two cards outside the trio
					for (int d = 0; d < `NUM_CARDS; d++) begin
						for (int e = d + 1; e < `NUM_CARDS; e++) begin
							if (d != a && d != b && d != c && e != a && e != b && e != c) begin
								fullRaw |= trioHit & sameRank[d][e];
							end
						end
					end
				end
			end
		end

		// any pair, and two pairs on four distinct cards
		for (int a = 0; a < `NUM_CARDS; a++) begin
			for (int b = a + 1; b < `NUM_CARDS; b++) begin
				anyPair |= sameRank[a][b];
				for (int c = a + 1; c < `NUM_CARDS; c++) begin
					for (int d = c + 1; d < `NUM_CARDS; d++) begin
						if (c != b && d != b) begin
							twoRaw |= sameRank[a][b] & sameRank[c][d];
						end
					end
				end
			end
		end

		// exclusion rules, strongest pattern wins
		fourFlag  = anyQuad;
		// five of one rank also looks like trio plus pair
		fullFlag  = fullRaw & ~anyQuad;
		threeFlag = anyTrio & ~fullRaw & ~anyQuad;
		twoFlag   = twoRaw & ~fullRaw & ~anyQuad;
		oneFlag   = anyPair & ~anyTrio & ~twoRaw;

		patterns.fourOfAKind  = fourFlag;
		patterns.fullHouse    = fullFlag;
		patterns.threeOfAKind = threeFlag;
		patterns.twoPairs     = twoFlag;
		patterns.onePair      = oneFlag;

		// ranker relies on a single pattern
		assert ($onehot0({fourFlag, fullFlag, threeFlag, twoFlag, oneFlag}))
			else $error("rankMultiplicity: more than one rank pattern at once");
	end

endmodule

/* design/straightDetector.sv */
`timescale 1ns/1ps
`include "poker_macros.svh"

module straightDetector import pokerPkg::*; (
	input handT hand,
	output logic straight
);

	// ace-low up to nine-king, plus ten-to-ace
	localparam int NUM_WINDOWS = `RANK_KING - `STRAIGHT_LEN + 2;

	// one bit per possible rank code, 0/14/15 included but never in a window
	logic [2**`RANK_W-1:0] rankPresent;
	logic [NUM_WINDOWS-1:0] windowHit;

	// which rank values occur
	always_comb begin
		rankPresent = '0;
		for (int i = 0; i < `NUM_CARDS; i++) begin
			rankPresent[hand[i].rank] = 1'b1;
		end
	end

	always_comb begin
		// sliding windows starting at the ace
		for (int w = 0; w < NUM_WINDOWS - 1; w++) begin
			windowHit[w] = &rankPresent[`RANK_ACE + w +: `STRAIGHT_LEN];
		end
		// ten to king, ace on top
		// no wrap past the ace, so king-ace-two is not counted
		windowHit[NUM_WINDOWS-1] = (&rankPresent[`RANK_KING -: `STRAIGHT_LEN-1])
			& rankPresent[`RANK_ACE];
	end

	assign straight = |windowHit;

	// five cards cover at most one window
	always_comb begin
		assert ($onehot0(windowHit))
			else $error("straightDetector: several straight windows match");
	end

endmodule

/* design/handRanker.sv */
`timescale 1ns/1ps
`include "poker_macros.svh"

module handRanker import pokerPkg::*; (
	input logic clk,
	input logic rstN,
	input handT hand,
	input logic handStrobe,
	patternIf.consumer patterns,
	input logic straight,
	output handCategoryE handType,
	output logic typeValid
);

	logic isFlush;
	handCategoryE nextType;

	// all suits match card 0
	always_comb begin
		isFlush = 1'b1;
		for (int i = 1; i < `NUM_CARDS; i++) begin
			isFlush &= (hand[i].suit == hand[0].suit);
		end
	end

	// suit and sequence outrank the rank patterns
	always_comb begin
		if (isFlush && straight) begin
			nextType = straightFlush;
		end else if (isFlush) begin
			nextType = flush;
		end else if (straight) begin
			nextType = pokerPkg::straight;
		end else if (patterns.fourOfAKind) begin
			nextType = fourOfAKind;
		end else if (patterns.fullHouse) begin
			nextType = fullHouse;
		end else if (patterns.threeOfAKind) begin
			nextType = threeOfAKind;
		end else if (patterns.twoPairs) begin
			nextType = twoPairs;
		end else if (patterns.onePair) begin
			nextType = onePair;
		end else begin
			nextType = highCard;
		end
	end

	// output stage
	always_ff @(posedge clk) begin
		if (!rstN) begin
			handType  <= highCard;
			typeValid <= 1'b0;
		end else begin
			typeValid <= handStrobe;
			// category holds between hands
			if (handStrobe) begin
				handType <= nextType;
			end
		end
	end

	// nothing comes out right after a reset cycle
	assert property (@(posedge clk) !rstN |=> !typeValid)
		else $error("handRanker: typeValid high after reset");

	// code stays inside the defined categories
	assert property (@(posedge clk) disable iff (!rstN) typeValid |-> handType <= straightFlush)
		else $error("handRanker: category code out of range");

endmodule

/* design/pokerHandClassifier.sv */
`timescale 1ns/1ps
`include "poker_macros.svh"

module pokerHandClassifier import pokerPkg::*; (
	input logic clk,
	input logic rstN,
	input logic handValid,
	input logic [`CARD_W-1:0] card0,
	input logic [`CARD_W-1:0] card1,
	input logic [`CARD_W-1:0] card2,
	input logic [`CARD_W-1:0] card3,
	input logic [`CARD_W-1:0] card4,
	output logic [`TYPE_W-1:0] handType,
	output logic typeValid
);

	// registered hand and its strobe
	handT handReg;
	logic handStrobe;
	logic straight;

	patternIf patterns();

	// cards only load on a strobe, card0 lands in the low slot
	always_ff @(posedge clk) begin
		if (handValid) begin
			handReg <= {card4, card3, card2, card1, card0};
		end
	end

	// strobe follows handValid every cycle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			handStrobe <= 1'b0;
		end else begin
			handStrobe <= handValid;
		end
	end

	// pairs, trips, quads
	rankMultiplicity i_rankMultiplicity (
		.hand(handReg),
		.patterns(patterns.producer)
	);

	// ten rank windows
	straightDetector i_straightDetector (
		.hand(handReg),
		.straight(straight)
	);

	// flush check, priority and output register
	handRanker i_handRanker (
		.clk(clk),
		.rstN(rstN),
		.hand(handReg),
		.handStrobe(handStrobe),
		.patterns(patterns.consumer),
		.straight(straight),
		.handType(handType),
		.typeValid(typeValid)
	);

endmodule

/* testbench/tbPokerHandClassifier.sv */
`timescale 1ns/1ps
`include "poker_macros.svh"

module tbPokerHandClassifier import pokerPkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_DIRECTED = 13;
	localparam int NUM_RANDOM = 2000;
	localparam int MAX_GAP = 3;
	localparam int MARGIN_CYCLES = 50;
	localparam int DRAIN_CYCLES = 4;
	// reset, settle, gapped and back-to-back directed, random slots, drain
	localparam int TEST_CYCLES = RESET_CYCLES + 4 + NUM_DIRECTED * 3
		+ NUM_RANDOM * (1 + MAX_GAP) + 8;

	logic clk;
	logic rstN;
	logic handValid;
	logic [`CARD_W-1:0] card0;
	logic [`CARD_W-1:0] card1;
	logic [`CARD_W-1:0] card2;
	logic [`CARD_W-1:0] card3;
	logic [`CARD_W-1:0] card4;
	logic [`TYPE_W-1:0] handType;
	logic typeValid;

	// expected categories in offer order
	handCategoryE expQ[$];
	// handValid as seen by the DUT, one stage per edge
	logic [1:0] strobeDelay;
	logic [31:0] rngState = 32'd74296;
	handT dirHands [NUM_DIRECTED];
	handCategoryE dirExpect [NUM_DIRECTED];

	pokerHandClassifier i_pokerHandClassifier (
		.clk(clk),
		.rstN(rstN),
		.handValid(handValid),
		.card0(card0),
		.card1(card1),
		.card2(card2),
		.card3(card3),
		.card4(card4),
		.handType(handType),
		.typeValid(typeValid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			abortRun($sformatf("CHECK FAILED at %0t: %s, got %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic drawCard(output cardT c);
		rngState = xorshift32(rngState);
		// rank 1..13 and suit from higher bits
		c.rank = rankT'((rngState % 32'd13) + 32'd1);
		c.suit = suitT'((rngState >> 8) % 32'd4);
	endtask

	function automatic cardT makeCard(input int suit, input int rank);
		cardT c;
		c.suit = suitT'(suit);
		c.rank = rankT'(rank);
		return c;
	endfunction

	function automatic handT makeHand(input cardT c0, input cardT c1, input cardT c2,
		input cardT c3, input cardT c4);
		return {c4, c3, c2, c1, c0};
	endfunction

	// expected category from rank counts, windows and suits
	function automatic handCategoryE refCategory(input handT h);
		int counts [16];
		int pairs;
		int trios;
		int quads;
		logic sameSuit;
		logic inRow;
		logic run;
		foreach (counts[r]) counts[r] = 0;
		for (int i = 0; i < `NUM_CARDS; i++) begin
			counts[h[i].rank]++;
		end
		pairs = 0;
		trios = 0;
		quads = 0;
		for (int r = 0; r < 16; r++) begin
			if (counts[r] == 2) pairs++;
			if (counts[r] == 3) trios++;
			if (counts[r] >= 4) quads++;
		end
		sameSuit = 1'b1;
		for (int i = 1; i < `NUM_CARDS; i++) begin
			if (h[i].suit != h[0].suit) sameSuit = 1'b0;
		end
		// windows starting at ace through nine
		run = 1'b0;
		for (int s = 1; s <= 9; s++) begin
			inRow = 1'b1;
			for (int k = 0; k < 5; k++) begin
				if (counts[s + k] != 1) inRow = 1'b0;
			end
			run |= inRow;
		end
		// ten to king with the ace on top
		if (counts[10] == 1 && counts[11] == 1 && counts[12] == 1 && counts[13] == 1
			&& counts[1] == 1) run = 1'b1;
		if (sameSuit && run) return straightFlush;
		if (sameSuit) return flush;
		if (run) return straight;
		if (quads > 0) return fourOfAKind;
		if (trios > 0 && pairs > 0) return fullHouse;
		if (trios > 0) return threeOfAKind;
		if (pairs >= 2) return twoPairs;
		if (pairs == 1) return onePair;
		return highCard;
	endfunction

	task automatic offerHand(input handT h, input handCategoryE expected);
		@(negedge clk);
		handValid = 1'b1;
		card0 = h[0];
		card1 = h[1];
		card2 = h[2];
		card3 = h[3];
		card4 = h[4];
		expQ.push_back(expected);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(negedge clk);
			handValid = 1'b0;
		end
	endtask

	task automatic loadDirected();
		dirHands[0] = makeHand(makeCard(0, 2), makeCard(1, 5), makeCard(2, 7),
			makeCard(3, 9), makeCard(0, 12));
		dirExpect[0] = highCard;
		dirHands[1] = makeHand(makeCard(0, 4), makeCard(1, 4), makeCard(2, 9),
			makeCard(3, 11), makeCard(0, 13));
		dirExpect[1] = onePair;
		dirHands[2] = makeHand(makeCard(0, 6), makeCard(1, 6), makeCard(2, 11),
			makeCard(3, 11), makeCard(0, 3));
		dirExpect[2] = twoPairs;
		dirHands[3] = makeHand(makeCard(0, 8), makeCard(1, 8), makeCard(2, 8),
			makeCard(3, 2), makeCard(0, 13));
		dirExpect[3] = threeOfAKind;
		dirHands[4] = makeHand(makeCard(0, 5), makeCard(1, 6), makeCard(2, 7),
			makeCard(3, 8), makeCard(0, 9));
		dirExpect[4] = straight;
		dirHands[5] = makeHand(makeCard(2, 2), makeCard(2, 5), makeCard(2, 9),
			makeCard(2, 11), makeCard(2, 13));
		dirExpect[5] = flush;
		dirHands[6] = makeHand(makeCard(0, 10), makeCard(1, 10), makeCard(2, 10),
			makeCard(3, 4), makeCard(0, 4));
		dirExpect[6] = fullHouse;
		// five of one rank holds a quad as well as a trio plus pair
		dirHands[7] = makeHand(makeCard(0, 12), makeCard(1, 12), makeCard(2, 12),
			makeCard(3, 12), makeCard(0, 12));
		dirExpect[7] = fourOfAKind;
		dirHands[8] = makeHand(makeCard(3, 9), makeCard(3, 10), makeCard(3, 11),
			makeCard(3, 12), makeCard(3, 13));
		dirExpect[8] = straightFlush;
		// ace low
		dirHands[9] = makeHand(makeCard(0, 1), makeCard(1, 2), makeCard(2, 3),
			makeCard(3, 4), makeCard(0, 5));
		dirExpect[9] = straight;
		// ace high
		dirHands[10] = makeHand(makeCard(1, 10), makeCard(2, 11), makeCard(3, 12),
			makeCard(0, 13), makeCard(1, 1));
		dirExpect[10] = straight;
		// no wrap around the ace
		dirHands[11] = makeHand(makeCard(0, 13), makeCard(1, 1), makeCard(2, 2),
			makeCard(3, 3), makeCard(0, 4));
		dirExpect[11] = highCard;
		dirHands[12] = makeHand(makeCard(1, 3), makeCard(1, 1), makeCard(1, 5),
			makeCard(1, 2), makeCard(1, 4));
		dirExpect[12] = straightFlush;
	endtask

	// DUT samples handValid on this edge and answers one edge later
	always @(posedge clk) begin
		if (!rstN) begin
			strobeDelay <= '0;
		end else begin
			strobeDelay <= {strobeDelay[0], handValid};
		end
	end

	// outputs only move on the rising edge
	always @(negedge clk) begin : compareResults
		handCategoryE expected;
		if (typeValid !== strobeDelay[1]) begin
			if (typeValid === 1'b1) begin
				abortRun("typeValid went high although no hand was taken in before it");
			end else begin
				abortRun("typeValid did not come after a hand was taken in");
			end
		end else if (typeValid) begin
			if (expQ.size() == 0) begin
				abortRun("typeValid went high while no result was outstanding");
			end else begin
				expected = expQ.pop_front();
				checkValue(32'(handType), 32'(expected), "hand category");
			end
		end
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		abortRun("timeout: the run took longer than the planned number of cycles");
	end

	initial begin
		handT h;
		cardT c;
		rstN = 1'b0;
		handValid = 1'b0;
		card0 = '0;
		card1 = '0;
		card2 = '0;
		card3 = '0;
		card4 = '0;
		loadDirected();
		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;
		// quiet after reset while the compare process watches typeValid
		idleCycles(4);

		// reference model against the known categories
		for (int n = 0; n < NUM_DIRECTED; n++) begin
			checkValue(32'(refCategory(dirHands[n])), 32'(dirExpect[n]), "reference model");
		end

		// one at a time with a gap
		for (int n = 0; n < NUM_DIRECTED; n++) begin
			offerHand(dirHands[n], dirExpect[n]);
			idleCycles(1);
		end

		// back to back
		for (int n = 0; n < NUM_DIRECTED; n++) begin
			offerHand(dirHands[n], dirExpect[n]);
		end
		idleCycles(2);

		// random hands with a gap of 0 to MAX_GAP cycles
		for (int n = 0; n < NUM_RANDOM; n++) begin
			for (int i = 0; i < `NUM_CARDS; i++) begin
				drawCard(c);
				h[i] = c;
			end
			offerHand(h, refCategory(h));
			rngState = xorshift32(rngState);
			idleCycles(int'((rngState >> 20) % (MAX_GAP + 1)));
		end

		// last result is due two edges after its offer
		idleCycles(DRAIN_CYCLES);
		if (expQ.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abortRun("results were still outstanding at the end of the run");
		end
	end

endmodule

/* filelist.f */
+incdir+include
design/pokerPkg.sv
design/patternIf.sv
design/rankMultiplicity.sv
design/straightDetector.sv
design/handRanker.sv
design/pokerHandClassifier.sv
testbench/tbPokerHandClassifier.sv

/* run.sh */
#!/bin/sh
set -e

# build testbench and RTL into one executable
verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f filelist.f \
	--top-module tbPokerHandClassifier \
	-o simPoker

# run and keep the log
./obj_dir/simPoker | tee sim.log

# the log decides the result
if grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
